//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;      // data or instruction word.
  typedef logic [31:0] addr_t;      // byte address, pc width.
  typedef logic [4:0]  reg_idx_t;   // register index.
  typedef logic [3:0]  alu_op_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [1:0]  op_a_sel_t;  // first alu operand source.
  typedef logic [1:0]  wb_sel_t;    // write-back source.

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // RV32I base opcodes, only the supported subset
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;

  localparam op_a_sel_t OPA_PC   = 2'd0;
  localparam op_a_sel_t OPA_ZERO = 2'd1;
  localparam op_a_sel_t OPA_RS1  = 2'd2;

  localparam wb_sel_t WB_ALU = 2'd0;
  localparam wb_sel_t WB_MEM = 2'd1;
  localparam wb_sel_t WB_PC4 = 2'd2;  // link address for jal.

  typedef struct packed {
    logic      branch;       // conditional branch.
    logic      jump;         // unconditional jump.
    logic      mem_write;
    logic      alu_src_imm;  // second operand is the immediate.
    logic      reg_write;
    op_a_sel_t op_a_sel;
    wb_sel_t   wb_sel;
    alu_op_t   alu_op;
    logic      illegal;      // opcode not supported.
  } ctrl_t;

endpackage

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  output rv_pkg::word_t   result,
  output logic            zero
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];  // only low five bits shift.

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);  // sign fill.
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

  assign zero = (result == '0);  // used by beq and bne.

endmodule

`default_nettype wire

//--- logic/instruction_decoder.sv
`default_nettype none

module instruction_decoder (
  input  rv_pkg::word_t instr,
  output rv_pkg::ctrl_t ctrl,
  output rv_pkg::word_t imm
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       bit30;
  logic       imm_alt;

  // funct3 plus the alternate bit pick the alu operation
  function automatic alu_op_t funct_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign bit30  = instr[30];
  assign imm_alt = bit30 && (funct3 == 3'b101);  // no subi, bit 30 is imm data.

  always_comb begin
    ctrl          = '0;
    ctrl.op_a_sel = OPA_RS1;
    ctrl.wb_sel   = WB_ALU;
    ctrl.alu_op   = ALU_ADD;
    case (opcode)
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = funct_to_op(funct3, bit30);
      end
      OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = funct_to_op(funct3, imm_alt);
      end
      OP_LOAD: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;  // rs1 + offset.
        ctrl.wb_sel      = WB_MEM;
      end
      OP_STORE: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;  // compare by subtraction.
      end
      OP_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_PC4;
      end
      OP_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.op_a_sel    = OPA_ZERO;  // 0 + imm.
      end
      OP_AUIPC: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.op_a_sel    = OPA_PC;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_STORE:
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      OP_BRANCH:
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      OP_JAL:
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      OP_LUI, OP_AUIPC:
        imm = {instr[31:12], 12'b0};
      default:
        imm = {{20{instr[31]}}, instr[31:20]};  // i-type.
    endcase
  end

  always_comb begin
    assert (ctrl.wb_sel != 2'b11)
      else $error("decoder produced unused write-back select");
  end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

module register_file (
  input  logic             CLK,
  input  logic             RESET_N,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd_idx,
  input  rv_pkg::word_t    rd_data,
  input  logic             we
);
  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_idx != '0)) begin  // x0 writes dropped.
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  // x0 must survive any attempted write
  x0_stays_zero: assert property (
    @(posedge CLK) disable iff (!RESET_N)
    (we && (rd_idx == '0)) |=> (regs[0] == '0)
  ) else $error("register x0 changed after write to x0");

endmodule

`default_nettype wire

//--- logic/instruction_memory.sv
`default_nettype none

module instruction_memory #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  CLK,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  rv_pkg::word_t         wdata,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output rv_pkg::word_t         rdata
);
  import rv_pkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  word_t mem [DEPTH];

  // program load port, used while the core is stopped
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr];  // fetch, same cycle.

endmodule

`default_nettype wire

//--- logic/data_memory.sv
`default_nettype none

module data_memory #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  CLK,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  rv_pkg::word_t         wdata,
  input  logic                  we,
  output rv_pkg::word_t         rdata
);
  import rv_pkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  word_t mem [DEPTH];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= wdata;  // sw lands at the retiring edge.
    end
  end

  assign rdata = mem[addr];  // lw data, zero latency.

endmodule

`default_nettype wire

//--- logic/single_cycle_core.sv
`default_nettype none

module single_cycle_core #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  CLK,
  input  logic                  RESET_N,
  input  logic                  run,
  input  rv_pkg::word_t         idata,
  output logic [ADDR_WIDTH-1:0] iaddr,
  output logic [ADDR_WIDTH-1:0] daddr,
  input  rv_pkg::word_t         ddata_r,
  output rv_pkg::word_t         ddata_w,
  output logic                  d_we,
  output logic                  reg_write_enable,
  output rv_pkg::reg_idx_t      write_register,
  output rv_pkg::word_t         reg_write_data
);
  import rv_pkg::*;

  addr_t      pc;
  addr_t      pc_plus4;
  addr_t      pc_target;
  addr_t      pc_next;
  ctrl_t      ctrl;
  word_t      imm;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_result;
  logic       alu_zero;
  logic       take_branch;
  logic [2:0] funct3;

  instruction_decoder decoder_i (
    .instr (idata),
    .ctrl  (ctrl),
    .imm   (imm)
  );

  register_file regs_i (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .rs1_idx  (idata[19:15]),
    .rs2_idx  (idata[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_idx   (write_register),
    .rd_data  (reg_write_data),
    .we       (reg_write_enable)
  );

  always_comb begin
    case (ctrl.op_a_sel)
      OPA_PC:   op_a = pc;  // auipc.
      OPA_ZERO: op_a = '0;  // lui.
      default:  op_a = rs1_data;
    endcase
  end

  assign op_b = ctrl.alu_src_imm ? imm : rs2_data;

  alu alu_i (
    .a      (op_a),
    .b      (op_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  reg_write_data = ddata_r;
      WB_PC4:  reg_write_data = pc_plus4;
      default: reg_write_data = alu_result;
    endcase
  end

  // nothing is committed while the core is stopped
  assign reg_write_enable = ctrl.reg_write & run;
  assign write_register   = idata[11:7];
  assign d_we             = ctrl.mem_write & run;
  assign daddr            = alu_result[ADDR_WIDTH+1:2];
  assign ddata_w          = rs2_data;

  assign funct3 = idata[14:12];
  assign take_branch = ctrl.branch &&
                       (((funct3 == 3'b000) && alu_zero) ||   // beq.
                        ((funct3 == 3'b001) && !alu_zero));   // bne.

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;
  assign pc_next   = (take_branch || ctrl.jump) ? pc_target : pc_plus4;
  assign iaddr     = pc[ADDR_WIDTH+1:2];

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      pc <= '0;
    end else if (run) begin  // pc holds while stopped.
      pc <= pc_next;
    end
  end

  no_illegal_when_running: assert property (
    @(posedge CLK) disable iff (!RESET_N)
    run |-> !ctrl.illegal
  ) else $error("illegal instruction fetched at pc %h", pc);

  pc_word_aligned: assert property (
    @(posedge CLK) disable iff (!RESET_N)
    run |=> (pc[1:0] == 2'b00)
  ) else $error("pc lost word alignment, pc %h", pc);

endmodule

`default_nettype wire

//--- logic/rv_system.sv
`default_nettype none

module rv_system #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  CLK,
  input  logic                  RESET_N,
  input  logic                  run,
  input  logic                  prog_we,
  input  logic [ADDR_WIDTH-1:0] prog_addr,
  input  rv_pkg::word_t         prog_data,
  output logic                  reg_write_enable,
  output rv_pkg::reg_idx_t      write_register,
  output rv_pkg::word_t         reg_write_data
);
  import rv_pkg::*;

  word_t                 idata;
  word_t                 ddata_r;
  word_t                 ddata_w;
  logic [ADDR_WIDTH-1:0] iaddr;
  logic [ADDR_WIDTH-1:0] daddr;
  logic                  d_we;

  single_cycle_core #(.ADDR_WIDTH(ADDR_WIDTH)) core_i (
    .CLK              (CLK),
    .RESET_N          (RESET_N),
    .run              (run),
    .idata            (idata),
    .iaddr            (iaddr),
    .daddr            (daddr),
    .ddata_r          (ddata_r),
    .ddata_w          (ddata_w),
    .d_we             (d_we),
    .reg_write_enable (reg_write_enable),
    .write_register   (write_register),
    .reg_write_data   (reg_write_data)
  );

  instruction_memory #(.ADDR_WIDTH(ADDR_WIDTH)) imem_i (
    .CLK   (CLK),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (iaddr),
    .rdata (idata)
  );

  data_memory #(.ADDR_WIDTH(ADDR_WIDTH)) dmem_i (
    .CLK   (CLK),
    .addr  (daddr),
    .wdata (ddata_w),
    .we    (d_we),
    .rdata (ddata_r)
  );

endmodule

`default_nettype wire

//--- testbench/rv_system_tb.sv
`default_nettype none

module rv_system_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  localparam int    ADDR_WIDTH  = 10;
  localparam int    CLK_PERIOD  = 10;
  localparam string GOLDEN_FILE = "testbench/program_golden.txt";

  typedef struct packed {
    reg_idx_t rd;
    word_t    value;
  } reg_write_t;

  logic                  CLK;
  logic                  RESET_N;
  logic                  run;
  logic                  prog_we;
  logic [ADDR_WIDTH-1:0] prog_addr;
  word_t                 prog_data;
  logic                  reg_write_enable;
  reg_idx_t              write_register;
  word_t                 reg_write_data;

  reg_write_t            expected_q[$];  // register writes in retire order.
  string                 name_q[$];
  logic [ADDR_WIDTH-1:0] load_addr_q[$];
  word_t                 load_word_q[$];
  int                    n_words;
  int                    n_writes;
  int                    seen;
  int                    errors;

  rv_system #(.ADDR_WIDTH(ADDR_WIDTH)) rv_system_i (
    .CLK              (CLK),
    .RESET_N          (RESET_N),
    .run              (run),
    .prog_we          (prog_we),
    .prog_addr        (prog_addr),
    .prog_data        (prog_data),
    .reg_write_enable (reg_write_enable),
    .write_register   (write_register),
    .reg_write_data   (reg_write_data)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic read_golden();
    int           fd;
    int           n;
    string        line;
    byte          kind;
    logic [31:0]  addr;
    word_t        value;
    int           rd;
    logic [127:0] name;
    fd = $fopen(GOLDEN_FILE, "r");
    assert (fd != 0) else begin
      errors++;
      $display("could not open %s", GOLDEN_FILE);
    end
    if (fd == 0) return;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() == 0) continue;
      kind = line.getc(0);
      if (kind == "P") begin
        n = $sscanf(line, "%c %h %h", kind, addr, value);
        load_addr_q.push_back(addr[ADDR_WIDTH-1:0]);
        load_word_q.push_back(value);
      end else if (kind == "W") begin
        n = $sscanf(line, "%c %d %h %s", kind, rd, value, name);
        expected_q.push_back('{rd: reg_idx_t'(rd), value: value});
        name_q.push_back(string'(name));  // drops leading null bytes.
      end
    end
    $fclose(fd);
    n_words  = load_addr_q.size();
    n_writes = expected_q.size();
    assert (n_words > 0 && n_writes > 0) else begin
      errors++;
      $display("golden file holds no program or no expected writes");
    end
  endtask

  task automatic load_program();
    foreach (load_addr_q[i]) begin
      @(posedge CLK);
      prog_we   <= 1'b1;
      prog_addr <= load_addr_q[i];
      prog_data <= load_word_q[i];
    end
    @(posedge CLK);
    prog_we <= 1'b0;
  endtask

  task automatic check_write(input reg_idx_t rd, input word_t value);
    reg_write_t exp;
    string      name;
    assert (expected_q.size() != 0) else begin
      errors++;
      $display("unexpected write to x%0d with %h after the last expected write", rd, value);
    end
    if (expected_q.size() != 0) begin
      exp  = expected_q.pop_front();
      name = name_q.pop_front();
      seen++;
      assert (rd == exp.rd && value == exp.value) else begin
        errors++;
        $display("Fail %s: expected x%0d = %h, actual x%0d = %h",
                 name, exp.rd, exp.value, rd, value);
      end
    end
  endtask

  task automatic finish_run();
    $display("checked %0d of %0d register writes, %0d errors", seen, n_writes, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic watchdog(input int limit_ns);
    #(limit_ns);
    errors++;
    $display("timeout at %0t: expected register writes not all observed (%0d of %0d)",
             $time, seen, n_writes);
    finish_run();
  endtask

  // write report is sampled before this edge commits it
  always @(posedge CLK) begin
    if (RESET_N && !run) begin
      assert (!reg_write_enable) else begin
        errors++;
        $display("register write reported while run is low, x%0d", write_register);
      end
    end
    if (RESET_N && reg_write_enable && write_register != '0) begin
      check_write(write_register, reg_write_data);
    end
  end

  initial begin
    CLK       = 1'b0;
    RESET_N   = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors    = 0;
    seen      = 0;
    read_golden();
    fork
      watchdog((n_words + n_writes) * 8 * CLK_PERIOD);
    join_none
    repeat (4) @(posedge CLK);
    RESET_N <= 1'b1;
    load_program();  // core is stopped here.
    @(posedge CLK);
    run <= 1'b1;
    while (seen < n_writes) begin
      @(posedge CLK);
    end
    repeat (2 * n_words) @(posedge CLK);  // room for stray writes.
    finish_run();
  end

endmodule

`default_nettype wire

//--- testbench/program_golden.txt
# P <imem word address, hex> <instruction, hex> [mnemonic]
# W <rd, decimal> <expected value, hex> <check name>, listed in retire order
P 00 00500093 addi x1, x0, 5
P 01 FFD00113 addi x2, x0, -3
P 02 002081B3 add x3, x1, x2
P 03 40208233 sub x4, x1, x2
P 04 401152B3 sra x5, x2, x1
P 05 00112333 slt x6, x2, x1
P 06 001133B3 sltu x7, x2, x1
P 07 0F00C413 xori x8, x1, 0xf0
P 08 40115493 srai x9, x2, 1
P 09 12345537 lui x10, 0x12345
P 0A 00001597 auipc x11, 0x1
P 0B 00A02623 sw x10, 12(x0)
P 0C 00402423 sw x4, 8(x0)
P 0D 00802603 lw x12, 8(x0)
P 0E 00C02683 lw x13, 12(x0)
P 0F 00108463 beq x1, x1, +8 taken
P 10 00100713 addi x14, x0, 1 skipped
P 11 00209463 bne x1, x2, +8 taken
P 12 00200713 addi x14, x0, 2 skipped
P 13 00208463 beq x1, x2, +8 not taken
P 14 00300713 addi x14, x0, 3
P 15 00700013 addi x0, x0, 7
P 16 000007B3 add x15, x0, x0
P 17 0080086F jal x16, +8
P 18 00900893 addi x17, x0, 9 skipped
P 19 0000006F jal x0, 0 self-loop
W 1 00000005 addi_pos
W 2 FFFFFFFD addi_neg
W 3 00000002 add
W 4 00000008 sub
W 5 FFFFFFFF sra_neg
W 6 00000001 slt_signed
W 7 00000000 sltu_unsigned
W 8 000000F5 xori
W 9 FFFFFFFE srai_neg
W 10 12345000 lui
W 11 00001028 auipc
W 12 00000008 lw_after_sw
W 13 12345000 lw_other_addr
W 14 00000003 branch_path
W 15 00000000 x0_read
W 16 00000060 jal_link

//--- flist.f
logic/rv_pkg.sv
logic/alu.sv
logic/instruction_decoder.sv
logic/register_file.sv
logic/instruction_memory.sv
logic/data_memory.sv
logic/single_cycle_core.sv
logic/rv_system.sv
testbench/rv_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_system testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module rv_system_tb -f flist.f -o rv_sim

./obj_dir/rv_sim 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
